//--- build.f
hdl/video_pkg.sv
hdl/video_ram_1r1w.sv
hdl/video_sprite_core.sv
hdl/video_pattern_gen.sv
hdl/video_regfile_axil.sv
hdl/video_overlay_top.sv
sim/tb_video_overlay.sv

//--- sim/tb_video_overlay.sv
/*
 * Testbench for the sprite overlay pipeline: AXI4-Lite setup, a shadow
 * model of the overlay rules and per-pixel checks at the output port
 */
`timescale 1ns/1ps
`default_nettype none

module tb_video_overlay import video_pkg::*; ();

    localparam int CLK_NS       = 20;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // roughly 200 bus transactions of up to 8 cycles each
    localparam int AXI_CYCLES   = 200 * 8;
    localparam int WATCHDOG_NS  = 2 * (6 * FRAME_CYCLES + AXI_CYCLES) * CLK_NS;

    logic              clk;
    logic              rst;
    logic [AXI_AW-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [AXI_DW-1:0] wdata;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [AXI_AW-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [AXI_DW-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    logic              out_ready;
    logic              out_vld;
    vga_frame_t        out_frame;

    // shadow copy of what the DUT was told
    logic                sh_en  [NUM_SPRITES];
    logic [H_SIZE-1:0]   sh_x0  [NUM_SPRITES];
    logic [V_SIZE-1:0]   sh_y0  [NUM_SPRITES];
    logic [RGB_SIZE-1:0] sh_mem [NUM_SPRITES][2**SPRITE_RAM_AW];

    logic [31:0]       seed;
    logic [31:0]       bp_rnd;
    int                errors;
    int                checks;
    string             test_name;
    // handshake between the main sequence and the output monitor
    logic              frame_req;
    logic              frame_done;
    logic              in_frame;
    logic              bp_en;
    int                pix_cnt;
    logic [H_SIZE-1:0] exp_hc;
    logic [V_SIZE-1:0] exp_vc;
    rgb_t              exp_color;
    logic              prev_vld;
    logic              prev_ready;
    vga_frame_t        prev_frame;

    video_overlay_top UUT (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .out_ready (out_ready),
        .out_vld   (out_vld),
        .out_frame (out_frame)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // bound covers six frames plus bus traffic, with margin
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests completed");
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // random numbers and the reference model
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [RGB_SIZE-1:0] sprite_word();
        logic [31:0] r;
        r = next_rand();
        // about one word in four is transparent
        if (r[31:30] == 2'b00) begin
            return KEY_COLOR;
        end
        return r[19:8];
    endfunction

    // background from the position, then sprites in index order
    function automatic rgb_t model_color(input int hc, input int vc);
        rgb_t                c;
        int                  dx;
        int                  dy;
        logic [RGB_SIZE-1:0] w;
        c.r = hc[3:0];
        c.g = vc[3:0];
        c.b = hc[3:0] ^ vc[3:0];
        for (int i = 0; i < NUM_SPRITES; i++) begin
            dx = hc - int'(sh_x0[i]);
            dy = vc - int'(sh_y0[i]);
            if (sh_en[i] && dx >= 0 && dx < SPRITE_HSIZE && dy >= 0 && dy < SPRITE_VSIZE) begin
                w = sh_mem[i][dx + dy * SPRITE_HSIZE];
                if (w != KEY_COLOR) begin
                    c = rgb_t'(w);
                end
            end
        end
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Mismatch %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else report_mismatch(name, exp, act);
    endtask

    // ------------------------------------------------------------------
    // AXI4-Lite bus
    // ------------------------------------------------------------------
    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_value("wready with awready", 1, wready);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        check_value("bresp", AXI_RESP_OKAY, bresp);
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        check_value("rresp", AXI_RESP_OKAY, rresp);
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic set_ctrl(input logic [31:0] v);
        axi_write(REG_CTRL, v);
        for (int i = 0; i < NUM_SPRITES; i++) begin
            sh_en[i] = v[i];
        end
    endtask

    task automatic set_origin(input int i, input logic [H_SIZE-1:0] x0,
                              input logic [V_SIZE-1:0] y0);
        axi_write(REG_ORIGIN_BASE + AXI_AW'(8 * i), 32'(x0));
        axi_write(REG_ORIGIN_BASE + AXI_AW'(8 * i + 4), 32'(y0));
        sh_x0[i] = x0;
        sh_y0[i] = y0;
    endtask

    // fill one whole sprite image, keys included
    task automatic load_sprite(input int i);
        logic [RGB_SIZE-1:0] w;
        for (int a = 0; a < 2**SPRITE_RAM_AW; a++) begin
            w = sprite_word();
            axi_write(RAM_BASE + AXI_AW'(256 * i + 4 * a), 32'(w));
            sh_mem[i][a] = w;
        end
    endtask

    // check one full frame that starts after the last write
    task automatic run_frame(input string name);
        repeat (10) @(posedge clk);
        test_name  = name;
        frame_done = 1'b0;
        frame_req  = 1'b1;
        wait (frame_done);
    endtask

    // ------------------------------------------------------------------
    // output monitor, sampled away from the driving edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        // a stalled edge must leave the output untouched
        if (!rst && prev_vld && !prev_ready) begin
            assert (out_vld && out_frame === prev_frame)
                else report_mismatch("stall hold", prev_frame, out_frame);
        end
        if (!rst && out_vld && out_ready) begin
            if (frame_req && !in_frame && out_frame.start) begin
                in_frame = 1'b1;
                exp_hc   = '0;
                exp_vc   = '0;
                pix_cnt  = 0;
            end
            if (in_frame) begin
                checks++;
                assert ({out_frame.vc, out_frame.hc, out_frame.start} ===
                        {exp_vc, exp_hc, (exp_hc == '0) && (exp_vc == '0)})
                    else report_mismatch({test_name, " position"}, {exp_vc, exp_hc},
                                         {out_frame.vc, out_frame.hc});
                exp_color = model_color(out_frame.hc, out_frame.vc);
                assert (out_frame.color === exp_color)
                    else report_mismatch(test_name, exp_color, out_frame.color);
                // raster order
                pix_cnt++;
                if (exp_hc == H_SIZE'(H_TOTAL - 1)) begin
                    exp_hc = '0;
                    exp_vc = (exp_vc == V_SIZE'(V_TOTAL - 1)) ? '0 : exp_vc + 1'b1;
                end else begin
                    exp_hc = exp_hc + 1'b1;
                end
                if (pix_cnt == FRAME_CYCLES) begin
                    in_frame   = 1'b0;
                    frame_req  = 1'b0;
                    frame_done = 1'b1;
                end
            end
        end
        prev_vld   = out_vld;
        prev_ready = out_ready;
        prev_frame = out_frame;
    end

    // random sink back-pressure, three cycles in four ready
    always @(posedge clk) begin
        if (bp_en) begin
            bp_rnd = next_rand();
            out_ready <= (bp_rnd[29:28] != 2'b00);
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0]       r;
        logic [31:0]       rd;
        logic [31:0]       ctrl;
        logic [H_SIZE-1:0] x0;
        logic [V_SIZE-1:0] y0;

        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        out_ready  = 1'b1;
        seed       = 32'h02b2fbee;
        errors     = 0;
        checks     = 0;
        bp_en      = 1'b0;
        frame_req  = 1'b0;
        frame_done = 1'b0;
        in_frame   = 1'b0;
        prev_vld   = 1'b0;
        prev_ready = 1'b1;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            sh_en[i] = 1'b0;
            sh_x0[i] = '0;
            sh_y0[i] = '0;
        end

        // reset for 5 edges, then one more idle cycle, first frame is background
        test_name = "reset";
        frame_req = 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            if (i == 4) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            assert (!out_vld && !bvalid && !rvalid && !awready && !arready) else begin
                errors++;
                $display("outputs not idle around reset, cycle %0d", i);
            end
        end
        wait (frame_done);

        // register readback
        for (int i = 0; i < NUM_SPRITES; i++) begin
            r = next_rand();
            set_origin(i, r[H_SIZE-1:0], r[8 +: V_SIZE]);
        end
        ctrl = next_rand() & ((1 << NUM_SPRITES) - 1);
        set_ctrl(ctrl);
        for (int i = 0; i < NUM_SPRITES; i++) begin
            axi_read(REG_ORIGIN_BASE + AXI_AW'(8 * i), rd);
            check_value("readback x0", 32'(sh_x0[i]), rd);
            axi_read(REG_ORIGIN_BASE + AXI_AW'(8 * i + 4), rd);
            check_value("readback y0", 32'(sh_y0[i]), rd);
        end
        axi_read(REG_CTRL, rd);
        check_value("readback ctrl", ctrl, rd);
        r = next_rand();
        axi_read(RAM_BASE + AXI_AW'(4 * r[5:0]), rd);
        check_value("readback ram window", 0, rd);

        set_ctrl(0);
        run_frame("background");

        // sprite 0 alone, kept inside the frame
        load_sprite(0);
        r  = next_rand();
        x0 = H_SIZE'(r[7:0] % 57);
        y0 = V_SIZE'(r[15:8] % 41);
        set_origin(0, x0, y0);
        set_ctrl(1);
        run_frame("single sprite");

        // sprite 1 overlaps the lower right of sprite 0
        load_sprite(1);
        set_origin(1, x0 + 3, y0 + 4);
        set_ctrl(3);
        run_frame("overlap");

        bp_en = 1'b1;
        run_frame("backpressure");
        bp_en = 1'b0;
        @(posedge clk);
        out_ready <= 1'b1;
        repeat (4) @(posedge clk);

        $display("checked %0d pixels, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/video_overlay_top.sv
/*
 * Sprite overlay pipeline: pattern source, chain of sprite cores and
 * AXI4-Lite configuration, with a valid/ready pixel output
 */
`timescale 1ns/1ps
`default_nettype none

module video_overlay_top import video_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    // AXI4-Lite slave
    input  wire  [AXI_AW-1:0] awaddr,
    input  wire               awvalid,
    output logic              awready,
    input  wire  [AXI_DW-1:0] wdata,
    input  wire               wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  wire               bready,
    input  wire  [AXI_AW-1:0] araddr,
    input  wire               arvalid,
    output logic              arready,
    output logic [AXI_DW-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  wire               rready,
    // pixel output
    input  wire               out_ready,
    output logic              out_vld,
    output vga_frame_t        out_frame
);

    // global freeze while the sink holds off
    logic                            stall;
    sprite_cfg_t [NUM_SPRITES-1:0]   cfg;
    sprite_wr_t                      wr;
    // link 0 leaves the generator, link NUM_SPRITES is the output
    logic                            link_vld   [NUM_SPRITES+1];
    vga_frame_t                      link_frame [NUM_SPRITES+1];

    assign stall = !out_ready;

    video_pattern_gen u_pattern_gen (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .vld   (link_vld[0]),
        .frame (link_frame[0])
    );

    video_regfile_axil u_regfile (
        .clk     (clk),     .rst     (rst),
        .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wvalid  (wvalid),  .wready  (wready),
        .bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
        .araddr  (araddr),  .arvalid (arvalid), .arready (arready),
        .rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid),
        .rready  (rready),
        .cfg     (cfg),
        .wr      (wr)
    );

    // ------------------------------------------------------------------
    // sprite chain, higher index paints on top
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_sprite
        video_sprite_core #(
            .SPRITE_ID (i)
        ) u_core (
            .clk          (clk),
            .rst          (rst),
            .stall        (stall),
            .cfg          (cfg[i]),
            .wr           (wr),
            .source_vld   (link_vld[i]),
            .source_frame (link_frame[i]),
            .sink_vld     (link_vld[i+1]),
            .sink_frame   (link_frame[i+1])
        );
    end

    assign out_vld   = link_vld[NUM_SPRITES];
    assign out_frame = link_frame[NUM_SPRITES];

endmodule

`default_nettype wire

//--- hdl/video_regfile_axil.sv
/*
 * AXI4-Lite register file: sprite enables, origins, and a write-only
 * window into the sprite memories
 */
`timescale 1ns/1ps
`default_nettype none

module video_regfile_axil import video_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    // write address and data
    input  wire  [AXI_AW-1:0]  awaddr,
    input  wire                awvalid,
    output logic               awready,
    input  wire  [AXI_DW-1:0]  wdata,
    input  wire                wvalid,
    output logic               wready,
    // write response
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  wire                bready,
    // read address and data
    input  wire  [AXI_AW-1:0]  araddr,
    input  wire                arvalid,
    output logic               arready,
    output logic [AXI_DW-1:0]  rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  wire                rready,
    // to the sprite cores
    output sprite_cfg_t [NUM_SPRITES-1:0] cfg,
    output sprite_wr_t         wr
);

    logic                     wr_acc;
    logic                     rd_acc;
    logic [AXI_AW-1:0]        ram_off;
    logic                     in_ram;
    logic [AXI_DW-1:0]        rd_val;

    logic                     wr_we;
    logic [SPRITE_IW-1:0]     wr_idx;
    logic [SPRITE_RAM_AW-1:0] wr_addr;
    logic [RGB_SIZE-1:0]      wr_data;

    // ------------------------------------------------------------------
    // handshake, address and data taken together
    // ------------------------------------------------------------------
    assign wr_acc  = awvalid && wvalid && !bvalid;
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign rd_acc  = arvalid && !rvalid;
    assign arready = rd_acc;

    // no error responses
    assign bresp = AXI_RESP_OKAY;
    assign rresp = AXI_RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_acc) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_acc) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // control and origin registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (wr_acc) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                if (awaddr == REG_CTRL) begin
                    cfg[i].en <= wdata[i];
                end
                if (awaddr == REG_ORIGIN_BASE + AXI_AW'(8 * i)) begin
                    cfg[i].x0 <= wdata[H_SIZE-1:0];
                end
                if (awaddr == REG_ORIGIN_BASE + AXI_AW'(8 * i + 4)) begin
                    cfg[i].y0 <= wdata[V_SIZE-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // sprite memory window, one write strobe per accepted beat
    // ------------------------------------------------------------------
    // bits 11:8 of the offset select the sprite, 7:2 the word
    assign ram_off = awaddr - RAM_BASE;
    assign in_ram  = (awaddr >= RAM_BASE) && (ram_off[AXI_AW-1:8] < NUM_SPRITES);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_we <= 1'b0;
        end else begin
            wr_we <= wr_acc && in_ram;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc && in_ram) begin
            wr_idx  <= ram_off[8 +: SPRITE_IW];
            wr_addr <= ram_off[2 +: SPRITE_RAM_AW];
            wr_data <= wdata[RGB_SIZE-1:0];
        end
    end

    assign wr = '{we: wr_we, idx: wr_idx, addr: wr_addr, data: wr_data};

    // ------------------------------------------------------------------
    // read mux, the memory window and unmapped space read as 0
    // ------------------------------------------------------------------
    always_comb begin
        rd_val = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (araddr == REG_CTRL) begin
                rd_val[i] = cfg[i].en;
            end
            if (araddr == REG_ORIGIN_BASE + AXI_AW'(8 * i)) begin
                rd_val = AXI_DW'(cfg[i].x0);
            end
            if (araddr == REG_ORIGIN_BASE + AXI_AW'(8 * i + 4)) begin
                rd_val = AXI_DW'(cfg[i].y0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata <= rd_val;
        end
    end

endmodule

`default_nettype wire

//--- hdl/video_pattern_gen.sv
/*
 * Pixel source, scans the frame in raster order and tags each position
 * with its background color
 */
`timescale 1ns/1ps
`default_nettype none

module video_pattern_gen import video_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        stall,
    output logic       vld,
    output vga_frame_t frame
);

    logic [H_SIZE-1:0] hc;
    logic [V_SIZE-1:0] vc;
    logic              last_col;
    logic              last_row;

    assign last_col = (hc == H_SIZE'(H_TOTAL - 1));
    assign last_row = (vc == V_SIZE'(V_TOTAL - 1));

    // ------------------------------------------------------------------
    // raster counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            hc  <= '0;
            vc  <= '0;
            vld <= 1'b0;
        end else if (!stall) begin
            // free running once out of reset
            vld <= 1'b1;
            if (last_col) begin
                hc <= '0;
                vc <= last_row ? '0 : vc + 1'b1;
            end else begin
                hc <= hc + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!stall) begin
            frame.hc    <= hc;
            frame.vc    <= vc;
            frame.start <= (hc == '0) && (vc == '0);
            frame.color <= bg_color(hc, vc);
        end
    end

endmodule

`default_nettype wire

//--- hdl/video_sprite_core.sv
/*
 * Sprite overlay core, two pipeline stages: map the pixel into sprite
 * space, then look up the sprite color and apply the key color
 */
`timescale 1ns/1ps
`default_nettype none

module video_sprite_core import video_pkg::*; #(
    parameter int SPRITE_ID = 0
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              stall,
    input  wire sprite_cfg_t cfg,
    input  wire sprite_wr_t  wr,
    // upstream pixel
    input  wire              source_vld,
    input  wire vga_frame_t  source_frame,
    // downstream pixel
    output logic             sink_vld,
    output vga_frame_t       sink_frame
);

    // one extra bit so positions left of or above the origin go negative
    logic [H_SIZE:0]          dx;
    logic [V_SIZE:0]          dy;
    logic                     in_region;
    logic [SPRITE_RAM_AW-1:0] addr_r;

    logic                     vld_s0;
    logic                     en_s0;
    logic                     hit_s0;
    logic [SPRITE_RAM_AW-1:0] addr_s0;
    vga_frame_t               frame_s0;

    logic                     ram_we;
    logic [RGB_SIZE-1:0]      ram_dout;
    logic                     keep_color;
    vga_frame_t               frame_s1;

    // ------------------------------------------------------------------
    // stage 0: sprite coordinates and region test
    // ------------------------------------------------------------------
    assign dx = {1'b0, source_frame.hc} - {1'b0, cfg.x0};
    assign dy = {1'b0, source_frame.vc} - {1'b0, cfg.y0};

    assign in_region = !dx[H_SIZE] && (dx[H_SIZE-1:0] < H_SIZE'(SPRITE_HSIZE)) &&
                       !dy[V_SIZE] && (dy[V_SIZE-1:0] < V_SIZE'(SPRITE_VSIZE));

    // row major image, addr = x + y * width
    assign addr_r = SPRITE_RAM_AW'(dx[H_SIZE-1:0] + dy[V_SIZE-1:0] * SPRITE_HSIZE);

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_s0   <= 1'b0;
            en_s0    <= 1'b0;
            sink_vld <= 1'b0;
        end else if (!stall) begin
            vld_s0   <= source_vld;
            en_s0    <= cfg.en;
            sink_vld <= vld_s0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            hit_s0   <= in_region;
            addr_s0  <= addr_r;
            frame_s0 <= source_frame;
        end
    end

    // ------------------------------------------------------------------
    // stage 1: lookup and chroma key
    // ------------------------------------------------------------------
    // background survives when disabled, outside, transparent, or no pixel
    assign keep_color = !en_s0 || !hit_s0 || (ram_dout == KEY_COLOR) || !vld_s0;

    always_comb begin
        frame_s1 = frame_s0;
        if (!keep_color) begin
            frame_s1.color = rgb_t'(ram_dout);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            sink_frame <= frame_s1;
        end
    end

    // shared write bus, only the addressed sprite takes it
    assign ram_we = wr.we && (wr.idx == SPRITE_IW'(SPRITE_ID));

    video_ram_1r1w #(
        .AW (SPRITE_RAM_AW),
        .DW (RGB_SIZE)
    ) u_sprite_ram (
        .clk    (clk),
        .we     (ram_we),
        .addr_w (wr.addr),
        .addr_r (addr_s0),
        .din    (wr.data),
        .dout   (ram_dout)
    );

endmodule

`default_nettype wire

//--- hdl/video_ram_1r1w.sv
/*
 * Sprite image memory, one synchronous write port and one asynchronous
 * read port
 */
`timescale 1ns/1ps
`default_nettype none

module video_ram_1r1w #(
    parameter int AW = 6,
    parameter int DW = 12
) (
    input  wire           clk,
    input  wire           we,
    input  wire  [AW-1:0] addr_w,
    input  wire  [AW-1:0] addr_r,
    input  wire  [DW-1:0] din,
    output logic [DW-1:0] dout
);

    // image storage, contents come only from the register bus
    logic [DW-1:0] mem [2**AW];

    // write port, never stalled so images can change mid frame
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr_w] <= din;
        end
    end

    // read port, combinational
    assign dout = mem[addr_r];

endmodule

`default_nettype wire

//--- hdl/video_pkg.sv
/*
 * Video overlay shared definitions: frame and sprite sizes, register map,
 * pixel and config types, and the background pattern
 */
`default_nettype none

package video_pkg;

    // ------------------------------------------------------------------
    // frame geometry, every position is active
    // ------------------------------------------------------------------
    localparam int H_SIZE  = 7;
    localparam int V_SIZE  = 6;
    localparam int H_TOTAL = 64;
    localparam int V_TOTAL = 48;

    // color depth, 4:4:4
    localparam int R_SIZE   = 4;
    localparam int G_SIZE   = 4;
    localparam int B_SIZE   = 4;
    localparam int RGB_SIZE = R_SIZE + G_SIZE + B_SIZE;

    // ------------------------------------------------------------------
    // sprites
    // ------------------------------------------------------------------
    localparam int NUM_SPRITES   = 2;
    localparam int SPRITE_IW     = $clog2(NUM_SPRITES);
    localparam int SPRITE_HSIZE  = 8;
    localparam int SPRITE_VSIZE  = 8;
    localparam int SPRITE_RAM_AW = 6;
    // transparent sprite pixel
    localparam logic [RGB_SIZE-1:0] KEY_COLOR = '0;

    // ------------------------------------------------------------------
    // AXI4-Lite register map
    // ------------------------------------------------------------------
    localparam int AXI_AW = 12;
    localparam int AXI_DW = 32;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    // bit i enables sprite i
    localparam logic [AXI_AW-1:0] REG_CTRL        = 12'h000;
    // x0 at base + 8i, y0 at base + 8i + 4
    localparam logic [AXI_AW-1:0] REG_ORIGIN_BASE = 12'h010;
    // one 0x100 window per sprite, word addressed
    localparam logic [AXI_AW-1:0] RAM_BASE        = 12'h100;

    typedef struct packed {
        logic [R_SIZE-1:0] r;
        logic [G_SIZE-1:0] g;
        logic [B_SIZE-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [H_SIZE-1:0] hc;
        logic [V_SIZE-1:0] vc;
        logic              start;   // first pixel of a frame
        rgb_t              color;
    } vga_frame_t;

    typedef struct packed {
        logic              en;
        logic [H_SIZE-1:0] x0;
        logic [V_SIZE-1:0] y0;
    } sprite_cfg_t;

    typedef struct packed {
        logic                     we;
        logic [SPRITE_IW-1:0]     idx;
        logic [SPRITE_RAM_AW-1:0] addr;
        logic [RGB_SIZE-1:0]      data;
    } sprite_wr_t;

    // checker-like background, r from hc, g from vc, b mixes both
    function automatic rgb_t bg_color(input logic [H_SIZE-1:0] hc,
                                      input logic [V_SIZE-1:0] vc);
        rgb_t c;
        c.r = hc[R_SIZE-1:0];
        c.g = vc[G_SIZE-1:0];
        c.b = hc[B_SIZE-1:0] ^ vc[B_SIZE-1:0];
        return c;
    endfunction

endpackage

`default_nettype wire
